//--- async_fifo.f
source/afifo_pkg.sv
source/afifo_dpram.sv
source/afifo_ptr_sync.sv
source/afifo_wr_ctrl.sv
source/afifo_rd_ctrl.sv
source/async_fifo.sv
test/async_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module async_fifo_tb \
  -f async_fifo.f \
  -o sim_async_fifo

sim_out="$(./obj_dir/sim_async_fifo 2>&1 || true)"
echo "$sim_out"

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

//--- source/afifo_dpram.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_dpram
  import afifo_pkg::*;
(
  input  wire   wr_clk,
  input  wire   wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  wire   rd_clk,
  input  wire   rd_rst_n,
  input  wire   rd_en,
  input  addr_t rd_addr,
  output data_t rd_data
);

  data_t mem [FIFO_DEPTH];

  // Write port, in the write clock domain.
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port.
  // The word stays on rd_data until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- source/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int PTR_WIDTH   = ADDR_WIDTH + 1;
  localparam int FIFO_AFULL  = FIFO_DEPTH - 1;
  localparam int FIFO_AEMPTY = 1;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Binary and Gray pointers share this type; the top bit is the wrap bit.
  typedef logic [PTR_WIDTH-1:0]  ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it.
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

//--- source/afifo_ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_ptr_sync
  import afifo_pkg::*;
(
  input  wire  clk,
  input  wire  rst_n,
  input  ptr_t gray_in,
  output ptr_t gray_out
);

  ptr_t meta_q;

  // First stage may go metastable; the second one settles it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q   <= '0;
      gray_out <= '0;
    end else begin
      meta_q   <= gray_in;
      gray_out <= meta_q;
    end
  end

  // A pointer seen across the crossing only moves forward, and never by
  // more than a full FIFO in one receiving clock.
  a_gray_forward: assert property (
    @(posedge clk) disable iff (!rst_n)
    ptr_t'(gray2bin(gray_out) - gray2bin($past(gray_out))) <= PTR_WIDTH'(FIFO_DEPTH)
  ) else $error("Synchronized pointer moved backward or jumped too far.");

endmodule

`default_nettype wire

//--- source/afifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_rd_ctrl
  import afifo_pkg::*;
(
  input  wire   rd_clk,
  input  wire   rd_rst_n,
  input  wire   rd_en,
  input  ptr_t  wr_gray_sync,
  output logic  rd_vld,
  output addr_t rd_addr,
  output ptr_t  rd_gray,
  output logic  empty,
  output logic  aempty
);

  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t wr_ptr_bin;
  ptr_t rd_fill;

  // Reads are ignored while empty.
  assign rd_vld = rd_en && !empty;

  always_comb begin
    if (rd_vld) begin
      rd_ptr_nxt = rd_ptr + 1'b1;
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  // RAM reads the current address on the edge that accepts the read.
  assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= bin2gray(rd_ptr_nxt);
    end
  end

  // Stale write pointer means data is only ever underestimated.
  assign wr_ptr_bin = gray2bin(wr_gray_sync);
  assign rd_fill    = wr_ptr_bin - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_fill == '0);
      aempty <= (rd_fill <= PTR_WIDTH'(FIFO_AEMPTY));
    end
  end

  a_no_rd_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    empty && rd_en |=> $stable(rd_ptr)
  ) else $error("Read pointer advanced while empty.");

  a_rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else $error("rd_gray changed by more than one bit.");

  // Reader can never pass the writer.
  a_no_underrun: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_fill <= PTR_WIDTH'(FIFO_DEPTH)
  ) else $error("Read pointer ran past the write pointer.");

endmodule

`default_nettype wire

//--- source/afifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_wr_ctrl
  import afifo_pkg::*;
(
  input  wire   wr_clk,
  input  wire   wr_rst_n,
  input  wire   wr_en,
  input  ptr_t  rd_gray_sync,
  output logic  wr_vld,
  output addr_t wr_addr,
  output ptr_t  wr_gray,
  output logic  full,
  output logic  afull
);

  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t rd_ptr_bin;
  ptr_t wr_fill;

  // Writes are dropped while full.
  assign wr_vld = wr_en && !full;

  always_comb begin
    if (wr_vld) begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];

  // Gray copy comes straight from a flop so the crossing sees clean edges.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= bin2gray(wr_ptr_nxt);
    end
  end

  // Read pointer as seen from this side lags the real one.
  // So the fill level can only be overestimated here.
  assign rd_ptr_bin = gray2bin(rd_gray_sync);
  assign wr_fill    = wr_ptr_nxt - rd_ptr_bin;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_fill == PTR_WIDTH'(FIFO_DEPTH));
      afull <= (wr_fill >= PTR_WIDTH'(FIFO_AFULL));
    end
  end

  a_no_wr_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    full && wr_en |=> $stable(wr_ptr)
  ) else $error("Write pointer advanced while full.");

  // Gray pointer must move one bit at a time.
  a_wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else $error("wr_gray changed by more than one bit.");

  a_fill_bound: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_fill <= PTR_WIDTH'(FIFO_DEPTH)
  ) else $error("Write side fill level exceeds the FIFO depth.");

endmodule

`default_nettype wire

//--- source/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo
  import afifo_pkg::*;
(
  input  wire   wr_clk,
  input  wire   wr_rst_n,
  input  wire   wr_en,
  input  data_t wr_data,
  input  wire   rd_clk,
  input  wire   rd_rst_n,
  input  wire   rd_en,
  output data_t rd_data,
  output logic  full,
  output logic  empty,
  output logic  afull,
  output logic  aempty
);

  logic  wr_vld;
  addr_t wr_addr;
  ptr_t  wr_gray;
  ptr_t  rd_gray_sync;

  logic  rd_vld;
  addr_t rd_addr;
  ptr_t  rd_gray;
  ptr_t  wr_gray_sync;

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_vld),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .wr_vld       (wr_vld),
    .wr_addr      (wr_addr),
    .wr_gray      (wr_gray),
    .full         (full),
    .afull        (afull)
  );

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .rd_vld       (rd_vld),
    .rd_addr      (rd_addr),
    .rd_gray      (rd_gray),
    .empty        (empty),
    .aempty       (aempty)
  );

  // Read pointer into the write domain.
  afifo_ptr_sync u_rd2wr_sync (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  // Write pointer into the read domain.
  afifo_ptr_sync u_wr2rd_sync (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

endmodule

`default_nettype wire

//--- test/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb
  import afifo_pkg::*;
();

  localparam int RANDOM_CYCLES   = 600;
  localparam int WAIT_LIMIT      = 20;
  localparam int WATCHDOG_CYCLES = 2 * RANDOM_CYCLES + 200 * FIFO_DEPTH;

  logic  wr_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_clk;
  logic  rd_rst_n;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  empty;
  logic  afull;
  logic  aempty;

  data_t model_q[$];
  data_t rd_exp;
  int    wr_count = 0;
  int    seed;

  async_fifo u_dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #5 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3.5 wr_clk = ~wr_clk;
  end

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // Reference model follows every accepted write.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_count++;
    end
  end

  // Accepted reads are compared once rd_data has settled
  always begin
    @(posedge rd_clk);
    if (rd_rst_n && rd_en && !empty) begin
      if (model_q.size() == 0) begin
        $display("A read was accepted while the reference model held no data");
        stop_with_failure();
      end else begin
        rd_exp = model_q.pop_front();
        @(negedge rd_clk);
        check_data("rd_data", rd_exp, rd_data);
      end
    end
  end

  task automatic write_word(input data_t d);
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = d;
    @(negedge wr_clk);
    wr_en   = 1'b0;
  endtask

  task automatic read_word();
    @(negedge rd_clk);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  task automatic wait_empty(input logic val);
    int n;
    n = 0;
    while (empty !== val && n < WAIT_LIMIT) begin
      @(negedge rd_clk);
      n++;
    end
    if (empty !== val) begin
      $display("empty did not become %b within %0d read clock cycles", val, WAIT_LIMIT);
      stop_with_failure();
    end
  endtask

  task automatic settle();
    repeat (10) @(negedge wr_clk);
    repeat (10) @(negedge rd_clk);
  endtask

  task automatic check_level(input int count);
    settle();
    check_count("stored words", count, model_q.size());
    check_flag("full", count == FIFO_DEPTH, full);
    check_flag("afull", count >= FIFO_AFULL, afull);
    check_flag("empty", count == 0, empty);
    check_flag("aempty", count <= FIFO_AEMPTY, aempty);
  endtask

  task automatic step_to(input int target);
    while (model_q.size() < target) begin
      write_word(data_t'($random(seed)));
    end
    while (model_q.size() > target) begin
      read_word();
    end
    check_level(target);
  endtask

  task automatic test_reset_state();
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_data("rd_data", '0, rd_data);
  endtask

  task automatic test_single_word();
    data_t word;
    word = 8'ha5;
    write_word(word);
    wait_empty(1'b0);
    read_word();
    check_data("rd_data", word, rd_data);
    wait_empty(1'b1);
    // Read while empty, with a different word behind the read address.
    read_word();
    check_data("rd_data", word, rd_data);
    check_count("stored words", 0, model_q.size());
  endtask

  task automatic test_fill_overflow();
    int start;
    int n;
    start = wr_count;
    n = 0;
    while (!full && n < 2 * FIFO_DEPTH) begin
      write_word(data_t'(8'h40 + n));
      n++;
    end
    check_count("accepted writes", FIFO_DEPTH, wr_count - start);
    // These land on a full FIFO and must vanish.
    repeat (4) write_word(8'hee);
    check_count("accepted writes", FIFO_DEPTH, wr_count - start);
    wait_empty(1'b0);
    repeat (FIFO_DEPTH) read_word();
    wait_empty(1'b1);
    check_count("stored words", 0, model_q.size());
  endtask

  task automatic test_thresholds();
    int levels [11] = '{0, 1, 2, 14, 15, 16, 15, 14, 2, 1, 0};
    foreach (levels[i]) begin
      step_to(levels[i]);
    end
  endtask

  task automatic test_random_stream();
    logic  wr_pat [RANDOM_CYCLES];
    logic  rd_pat [RANDOM_CYCLES];
    data_t data_pat [RANDOM_CYCLES];
    int    r;
    int    n;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      r = $random(seed);
      wr_pat[i]   = r[3];
      rd_pat[i]   = r[9];
      data_pat[i] = r[23:16];
    end
    fork
      begin
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
          @(negedge wr_clk);
          wr_en   = wr_pat[i];
          wr_data = data_pat[i];
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
      end
      begin
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
          @(negedge rd_clk);
          rd_en = rd_pat[i];
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
      end
    join
    settle();
    n = 0;
    while (model_q.size() > 0 && n < 2 * FIFO_DEPTH) begin
      read_word();
      n++;
    end
    wait_empty(1'b1);
    check_count("stored words", 0, model_q.size());
  endtask

  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    seed     = 32'h37f0;
    repeat (8) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    test_reset_state();
    test_single_word();
    test_fill_overflow();
    test_thresholds();
    test_random_stream();
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge rd_clk);
    $display("Timeout: the tests did not finish within %0d read clock cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

endmodule

`default_nettype wire
